//--- design/opd_pkg.sv
`default_nettype none

package opd_pkg;

  // alu operations seen on the issue port
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_slt  = 4'd7,
    op_addi = 4'd8
  } alu_op_e;

  // default datapath sizes
  parameter int data_width_def = 32;
  parameter int num_regs_def   = 32;

  // apb byte offsets of the configuration block
  parameter logic [11:0] csr_ctrl_off   = 12'h000;
  parameter logic [11:0] csr_commit_off = 12'h004;
  parameter logic [11:0] csr_squash_off = 12'h008;
  parameter logic [11:0] csr_id_off     = 12'h00c;

  // identity word
  parameter logic [31:0] opd_id = 32'h0bd5_0001;

endpackage

`default_nettype wire

//--- design/dpram.sv
`default_nettype none

module dpram #(
  parameter int WIDTH   = opd_pkg::data_width_def,
  parameter int NUMREGS = opd_pkg::num_regs_def
) (
  input  logic                       clk,
  input  logic [$clog2(NUMREGS)-1:0] waddr,
  input  logic                       we,
  input  logic [WIDTH-1:0]           wdata,
  input  logic [$clog2(NUMREGS)-1:0] raddr,
  output logic [WIDTH-1:0]           rdata
);

  // storage starts cleared so register zero reads zero
  logic [WIDTH-1:0] mem [NUMREGS] = '{default: '0};

  // read returns old contents when the same word is written on this edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- design/rf_bank.sv
`default_nettype none

module rf_bank #(
  parameter int WIDTH   = opd_pkg::data_width_def,
  parameter int NUMREGS = opd_pkg::num_regs_def
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [$clog2(NUMREGS)-1:0] waddr,
  input  logic                       we,
  input  logic [WIDTH-1:0]           wdata,
  input  logic [$clog2(NUMREGS)-1:0] raddr,
  input  logic                       ren,
  output logic [WIDTH-1:0]           rdata
);

  localparam int AW = $clog2(NUMREGS);

  logic [AW-1:0] hold_addr;
  logic [AW-1:0] ram_raddr;

  // last enabled read address
  always_ff @(posedge clk) begin
    if (!resetn) begin
      hold_addr <= '0;
    end else if (ren) begin
      hold_addr <= raddr;
    end
  end

  // re-read the held register while disabled, picks up new writes
  assign ram_raddr = ren ? raddr : hold_addr;

  dpram #(
    .WIDTH  (WIDTH),
    .NUMREGS(NUMREGS)
  ) u_dpram (
    .clk  (clk),
    .waddr(waddr),
    .we   (we),
    .wdata(wdata),
    .raddr(ram_raddr),
    .rdata(rdata)
  );

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file #(
  parameter int WIDTH   = opd_pkg::data_width_def,
  parameter int NUMREGS = opd_pkg::num_regs_def
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [$clog2(NUMREGS)-1:0] a_reg,
  input  logic                       a_en,
  input  logic [$clog2(NUMREGS)-1:0] b_reg,
  input  logic                       b_en,
  input  logic [$clog2(NUMREGS)-1:0] c_reg,
  input  logic [WIDTH-1:0]           c_data,
  input  logic                       c_we,
  input  logic                       c_squashn,
  output logic [WIDTH-1:0]           a_data,
  output logic [WIDTH-1:0]           b_data
);

  logic bank_we;

  // squashed results and register zero never reach storage
  assign bank_we = c_we & c_squashn & (|c_reg);

  // two copies give two reads per cycle next to one write
  rf_bank #(
    .WIDTH  (WIDTH),
    .NUMREGS(NUMREGS)
  ) u_bank_a (
    .clk   (clk),
    .resetn(resetn),
    .waddr (c_reg),
    .we    (bank_we),
    .wdata (c_data),
    .raddr (a_reg),
    .ren   (a_en),
    .rdata (a_data)
  );

  rf_bank #(
    .WIDTH  (WIDTH),
    .NUMREGS(NUMREGS)
  ) u_bank_b (
    .clk   (clk),
    .resetn(resetn),
    .waddr (c_reg),
    .we    (bank_we),
    .wdata (c_data),
    .raddr (b_reg),
    .ren   (b_en),
    .rdata (b_data)
  );

endmodule

`default_nettype wire

//--- design/alu.sv
`default_nettype none

module alu #(
  parameter int WIDTH = opd_pkg::data_width_def
) (
  input  opd_pkg::alu_op_e op,
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  input  logic [WIDTH-1:0] imm,
  output logic [WIDTH-1:0] result
);

  import opd_pkg::*;

  localparam int SHW = $clog2(WIDTH);

  logic [SHW-1:0] shamt;
  logic           lt;

  // shift amount from the low bits of y
  assign shamt = y[SHW-1:0];
  assign lt    = $signed(x) < $signed(y);

  always_comb begin
    case (op)
      op_add: begin
        result = x + y;
      end
      op_sub: begin
        result = x - y;
      end
      op_and: begin
        result = x & y;
      end
      op_or: begin
        result = x | y;
      end
      op_xor: begin
        result = x ^ y;
      end
      op_sll: begin
        result = x << shamt;
      end
      op_srl: begin
        result = x >> shamt;
      end
      op_slt: begin
        result = {{(WIDTH-1){1'b0}}, lt};
      end
      op_addi: begin
        // second operand unused here
        result = x + imm;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/exec_pipe.sv
`default_nettype none

module exec_pipe #(
  parameter int WIDTH   = opd_pkg::data_width_def,
  parameter int NUMREGS = opd_pkg::num_regs_def
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       stall,
  input  logic                       issue_valid,
  input  opd_pkg::alu_op_e           issue_op,
  input  logic [$clog2(NUMREGS)-1:0] issue_rd,
  input  logic [$clog2(NUMREGS)-1:0] issue_rs,
  input  logic [$clog2(NUMREGS)-1:0] issue_rt,
  input  logic [WIDTH-1:0]           issue_imm,
  input  logic [WIDTH-1:0]           a_data,
  input  logic [WIDTH-1:0]           b_data,
  input  logic                       wb_enable,
  output logic [$clog2(NUMREGS)-1:0] a_reg,
  output logic                       a_en,
  output logic [$clog2(NUMREGS)-1:0] b_reg,
  output logic                       b_en,
  output logic [$clog2(NUMREGS)-1:0] c_reg,
  output logic [WIDTH-1:0]           c_data,
  output logic                       c_we,
  output logic                       wb_valid,
  output logic [$clog2(NUMREGS)-1:0] wb_rd,
  output logic [WIDTH-1:0]           wb_data,
  output logic                       wb_commit,
  output logic                       wb_squash
);

  import opd_pkg::*;

  localparam int AW = $clog2(NUMREGS);

  logic             accept;
  logic             ex_valid;
  alu_op_e          ex_op;
  logic [AW-1:0]    ex_rd;
  logic [AW-1:0]    ex_rs;
  logic [AW-1:0]    ex_rt;
  logic [WIDTH-1:0] ex_imm;
  logic [WIDTH-1:0] x_opnd;
  logic [WIDTH-1:0] y_opnd;
  logic [WIDTH-1:0] alu_res;
  logic             wb_fwd;
  logic             ret_valid;
  logic [AW-1:0]    ret_rd;
  logic [WIDTH-1:0] ret_data;

  assign accept = issue_valid & ~stall;

  // bank reads are sampled on the accept edge
  assign a_reg = issue_rs;
  assign b_reg = issue_rt;
  assign a_en  = accept;
  assign b_en  = accept;

  // writeback result counts for forwarding only if it will be committed
  assign wb_fwd = wb_valid & wb_enable & (wb_rd != '0);

  // newest source first: writeback stage, then retire entry
  always_comb begin
    x_opnd = a_data;
    if (wb_fwd && (wb_rd == ex_rs)) begin
      x_opnd = wb_data;
    end else if (ret_valid && (ret_rd == ex_rs)) begin
      x_opnd = ret_data;
    end
  end

  always_comb begin
    y_opnd = b_data;
    if (wb_fwd && (wb_rd == ex_rt)) begin
      y_opnd = wb_data;
    end else if (ret_valid && (ret_rd == ex_rt)) begin
      y_opnd = ret_data;
    end
  end

  alu #(
    .WIDTH(WIDTH)
  ) u_alu (
    .op    (ex_op),
    .x     (x_opnd),
    .y     (y_opnd),
    .imm   (ex_imm),
    .result(alu_res)
  );

  // execute and writeback valids
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else if (!stall) begin
      ex_valid <= issue_valid;
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_op  <= issue_op;
      ex_rd  <= issue_rd;
      ex_rs  <= issue_rs;
      ex_rt  <= issue_rt;
      ex_imm <= issue_imm;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && ex_valid) begin
      wb_rd   <= ex_rd;
      wb_data <= alu_res;
    end
  end

  // result leaves the stage on an unstalled edge
  assign c_we      = wb_valid & ~stall;
  assign c_reg     = wb_rd;
  assign c_data    = wb_data;
  assign wb_commit = c_we & wb_enable;
  assign wb_squash = c_we & ~wb_enable;

  // retire entry keeps the last result that actually reached the banks
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ret_valid <= 1'b0;
    end else if (wb_commit && (wb_rd != '0)) begin
      ret_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_commit && (wb_rd != '0)) begin
      ret_rd   <= wb_rd;
      ret_data <= wb_data;
    end
  end

endmodule

`default_nettype wire

//--- design/csr_apb.sv
`default_nettype none

module csr_apb (
  input  logic        clk,
  input  logic        resetn,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  input  logic        wb_commit,
  input  logic        wb_squash,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        wb_enable
);

  import opd_pkg::*;

  logic [31:0] commit_cnt;
  logic [31:0] squash_cnt;
  logic        access;
  logic        hit_ctrl;
  logic        hit_commit;
  logic        hit_squash;
  logic        hit_id;
  logic        mapped;
  logic        wr;

  // counters stick at all ones
  function automatic logic [31:0] sat_inc(input logic [31:0] v);
    return (&v) ? v : v + 32'd1;
  endfunction

  assign access     = psel & penable;
  assign hit_ctrl   = (paddr == csr_ctrl_off);
  assign hit_commit = (paddr == csr_commit_off);
  assign hit_squash = (paddr == csr_squash_off);
  assign hit_id     = (paddr == csr_id_off);
  assign mapped     = hit_ctrl | hit_commit | hit_squash | hit_id;

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access & (~mapped | (pwrite & hit_id));
  assign wr      = access & pwrite & ~pslverr;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wb_enable <= 1'b1;
    end else if (wr && hit_ctrl) begin
      wb_enable <= pwdata[0];
    end
  end

  // a write clears, whatever the data
  always_ff @(posedge clk) begin
    if (!resetn) begin
      commit_cnt <= '0;
    end else if (wr && hit_commit) begin
      commit_cnt <= '0;
    end else if (wb_commit) begin
      commit_cnt <= sat_inc(commit_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      squash_cnt <= '0;
    end else if (wr && hit_squash) begin
      squash_cnt <= '0;
    end else if (wb_squash) begin
      squash_cnt <= sat_inc(squash_cnt);
    end
  end

  // read data
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (hit_ctrl) begin
        prdata = {31'd0, wb_enable};
      end else if (hit_commit) begin
        prdata = commit_cnt;
      end else if (hit_squash) begin
        prdata = squash_cnt;
      end else if (hit_id) begin
        prdata = opd_id;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/opd_top.sv
`default_nettype none

module opd_top #(
  parameter int WIDTH   = opd_pkg::data_width_def,
  parameter int NUMREGS = opd_pkg::num_regs_def
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       stall,
  input  logic                       issue_valid,
  input  opd_pkg::alu_op_e           issue_op,
  input  logic [$clog2(NUMREGS)-1:0] issue_rd,
  input  logic [$clog2(NUMREGS)-1:0] issue_rs,
  input  logic [$clog2(NUMREGS)-1:0] issue_rt,
  input  logic [WIDTH-1:0]           issue_imm,
  output logic                       wb_valid,
  output logic [$clog2(NUMREGS)-1:0] wb_rd,
  output logic [WIDTH-1:0]           wb_data,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [11:0]                paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr
);

  localparam int AW = $clog2(NUMREGS);

  logic [AW-1:0]    a_reg;
  logic             a_en;
  logic [AW-1:0]    b_reg;
  logic             b_en;
  logic [WIDTH-1:0] a_data;
  logic [WIDTH-1:0] b_data;
  logic [AW-1:0]    c_reg;
  logic [WIDTH-1:0] c_data;
  logic             c_we;
  logic             wb_enable;
  logic             wb_commit;
  logic             wb_squash;

  exec_pipe #(
    .WIDTH  (WIDTH),
    .NUMREGS(NUMREGS)
  ) u_exec_pipe (
    .clk        (clk),
    .resetn     (resetn),
    .stall      (stall),
    .issue_valid(issue_valid),
    .issue_op   (issue_op),
    .issue_rd   (issue_rd),
    .issue_rs   (issue_rs),
    .issue_rt   (issue_rt),
    .issue_imm  (issue_imm),
    .a_data     (a_data),
    .b_data     (b_data),
    .wb_enable  (wb_enable),
    .a_reg      (a_reg),
    .a_en       (a_en),
    .b_reg      (b_reg),
    .b_en       (b_en),
    .c_reg      (c_reg),
    .c_data     (c_data),
    .c_we       (c_we),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_commit  (wb_commit),
    .wb_squash  (wb_squash)
  );

  // squash comes straight from the control bit
  reg_file #(
    .WIDTH  (WIDTH),
    .NUMREGS(NUMREGS)
  ) u_reg_file (
    .clk      (clk),
    .resetn   (resetn),
    .a_reg    (a_reg),
    .a_en     (a_en),
    .b_reg    (b_reg),
    .b_en     (b_en),
    .c_reg    (c_reg),
    .c_data   (c_data),
    .c_we     (c_we),
    .c_squashn(wb_enable),
    .a_data   (a_data),
    .b_data   (b_data)
  );

  csr_apb u_csr_apb (
    .clk      (clk),
    .resetn   (resetn),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .wb_commit(wb_commit),
    .wb_squash(wb_squash),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .wb_enable(wb_enable)
  );

endmodule

`default_nettype wire

//--- verif/opd_tb.sv
`default_nettype none

module opd_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import opd_pkg::*;

  logic        clk = 1'b0;
  logic        resetn;
  logic        stall;
  logic        issue_valid;
  alu_op_e     issue_op;
  logic [4:0]  issue_rd;
  logic [4:0]  issue_rs;
  logic [4:0]  issue_rt;
  logic [31:0] issue_imm;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // stimulus table
  string       row_name  [64];
  alu_op_e     row_op    [64];
  logic [4:0]  row_rd    [64];
  logic [4:0]  row_rs    [64];
  logic [4:0]  row_rt    [64];
  logic [31:0] row_imm   [64];
  int          row_stall [64];
  logic        row_wben  [64];
  int          n_rows = 0;

  // reference model state
  logic [31:0] model_regs [32];
  int          model_commits = 0;
  int          model_squashes = 0;
  logic        cur_wben = 1'b1;

  // outstanding results in issue order
  logic [31:0] exp_data_q [$];
  logic [4:0]  exp_rd_q [$];
  int          exp_row_q [$];
  int          acc_q [$];

  logic [31:0] lfsr = 32'hf9fe_0b47;
  int          edge_idx = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;
  int          checks = 0;
  int          errors = 0;

  opd_top #(
    .WIDTH  (32),
    .NUMREGS(32)
  ) dut (
    .clk        (clk),
    .resetn     (resetn),
    .stall      (stall),
    .issue_valid(issue_valid),
    .issue_op   (issue_op),
    .issue_rd   (issue_rd),
    .issue_rs   (issue_rs),
    .issue_rt   (issue_rt),
    .issue_imm  (issue_imm),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  always #2 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    int          i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] x,
                                          input logic [31:0] y, input logic [31:0] imm);
    logic [31:0] r;
    case (op)
      op_add:  r = x + y;
      op_sub:  r = x - y;
      op_and:  r = x & y;
      op_or:   r = x | y;
      op_xor:  r = x ^ y;
      op_sll:  r = x << y[4:0];
      op_srl:  r = x >> y[4:0];
      op_slt:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      op_addi: r = x + imm;
      default: r = 32'd0;
    endcase
    return r;
  endfunction

  task automatic add_row(input string name, input alu_op_e op, input int rd, input int rs,
                         input int rt, input logic [31:0] imm, input int stalls,
                         input logic wben);
    row_name[n_rows]  = name;
    row_op[n_rows]    = op;
    row_rd[n_rows]    = 5'(rd);
    row_rs[n_rows]    = 5'(rs);
    row_rt[n_rows]    = 5'(rt);
    row_imm[n_rows]   = imm;
    row_stall[n_rows] = stalls;
    row_wben[n_rows]  = wben;
    n_rows++;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("error %s expected 0x%08h actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    assert (pready === 1'b1) else begin
      $display("pready was low in the access phase of an apb transfer");
      errors++;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_check(input string name, input logic wr, input logic [11:0] addr,
                           input logic [31:0] wdata, input logic chk_data,
                           input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(wr, addr, wdata, rdata, err);
    check_value({name, " pslverr"}, {31'd0, exp_err}, {31'd0, err});
    if (chk_data) begin
      check_value({name, " prdata"}, exp_data, rdata);
    end
  endtask

  task automatic drain_pipe();
    @(negedge clk);
    issue_valid = 1'b0;
    stall       = 1'b0;
    while (exp_data_q.size() > 0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_row(input int r);
    logic [31:0] res;
    logic [31:0] ctrl_val;
    int          i;
    // control bit only changes with the pipeline empty
    if (row_wben[r] != cur_wben) begin
      drain_pipe();
      ctrl_val = {31'd0, row_wben[r]};
      apb_check({row_name[r], " ctrl write"}, 1'b1, csr_ctrl_off, ctrl_val, 1'b0, 32'd0, 1'b0);
      apb_check({row_name[r], " ctrl read"}, 1'b0, csr_ctrl_off, 32'd0, 1'b1, ctrl_val, 1'b0);
      cur_wben = row_wben[r];
    end
    for (i = 0; i <= row_stall[r]; i++) begin
      @(negedge clk);
      issue_valid = 1'b1;
      issue_op    = row_op[r];
      issue_rd    = row_rd[r];
      issue_rs    = row_rs[r];
      issue_rt    = row_rt[r];
      issue_imm   = row_imm[r];
      stall       = (i < row_stall[r]);
    end
    res = ref_alu(row_op[r], model_regs[row_rs[r]], model_regs[row_rt[r]], row_imm[r]);
    exp_data_q.push_back(res);
    exp_rd_q.push_back(row_rd[r]);
    exp_row_q.push_back(r);
    if (row_wben[r]) begin
      model_commits++;
      if (row_rd[r] != 5'd0) begin
        model_regs[row_rd[r]] = res;
      end
    end else begin
      model_squashes++;
    end
  endtask

  // a result leaves on the second unstalled edge after its accept
  always @(negedge clk) begin
    int acc;
    int r;
    #1;
    if (resetn) begin
      if (wb_valid && !stall) begin
        assert (exp_data_q.size() > 0 && acc_q.size() > 0) else begin
          $display("a result left the writeback port with no operation outstanding");
          errors++;
        end
        if (exp_data_q.size() > 0 && acc_q.size() > 0) begin
          r   = exp_row_q.pop_front();
          acc = acc_q.pop_front();
          check_value({row_name[r], " wb_rd"}, {27'd0, exp_rd_q.pop_front()}, {27'd0, wb_rd});
          check_value({row_name[r], " wb_data"}, exp_data_q.pop_front(), wb_data);
          check_value({row_name[r], " latency"}, 32'd2, 32'(edge_idx - acc));
        end
      end
      if (issue_valid && !stall) begin
        acc_q.push_back(edge_idx);
      end
      if (!stall) begin
        edge_idx++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    int r;
    resetn      = 1'b0;
    stall       = 1'b0;
    issue_valid = 1'b0;
    issue_op    = op_add;
    issue_rd    = '0;
    issue_rs    = '0;
    issue_rt    = '0;
    issue_imm   = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    for (r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end

    // operands through addi before every operation
    add_row("ld_r1", op_addi, 1, 0, 0, rand_word(), 0, 1'b1);
    add_row("ld_r2", op_addi, 2, 0, 0, rand_word(), 0, 1'b1);
    add_row("ld_r3", op_addi, 3, 0, 0, rand_word(), 0, 1'b1);
    add_row("ld_r4", op_addi, 4, 0, 0, rand_word(), 0, 1'b1);
    add_row("ld_r5", op_addi, 5, 0, 0, 32'hffff_fff0, 0, 1'b1);
    add_row("ld_r6", op_addi, 6, 0, 0, 32'd5, 0, 1'b1);
    add_row("alu_add", op_add, 7, 1, 2, 32'd0, 0, 1'b1);
    add_row("alu_sub", op_sub, 8, 1, 2, 32'd0, 0, 1'b1);
    add_row("alu_and", op_and, 9, 1, 4, 32'd0, 0, 1'b1);
    add_row("alu_or", op_or, 10, 2, 4, 32'd0, 0, 1'b1);
    add_row("alu_xor", op_xor, 11, 3, 4, 32'd0, 0, 1'b1);
    add_row("alu_sll", op_sll, 12, 1, 3, 32'd0, 0, 1'b1);
    add_row("alu_srl", op_srl, 13, 2, 3, 32'd0, 0, 1'b1);
    add_row("alu_slt_neg", op_slt, 14, 5, 6, 32'd0, 0, 1'b1);
    add_row("alu_slt_pos", op_slt, 15, 6, 5, 32'd0, 0, 1'b1);
    add_row("alu_slt_rand", op_slt, 16, 1, 2, 32'd0, 0, 1'b1);
    // forwarding at distance one and two and writes to register zero
    add_row("dep_base", op_addi, 17, 0, 0, 32'd100, 0, 1'b1);
    add_row("dep_dist1", op_add, 18, 17, 17, 32'd0, 0, 1'b1);
    add_row("dep_dist2", op_sub, 19, 18, 17, 32'd0, 0, 1'b1);
    add_row("dep_both", op_xor, 20, 19, 18, 32'd0, 0, 1'b1);
    add_row("r0_write", op_addi, 0, 1, 0, 32'd55, 0, 1'b1);
    add_row("r0_read", op_add, 21, 0, 0, 32'd0, 0, 1'b1);
    add_row("r0_or", op_or, 22, 0, 17, 32'd0, 0, 1'b1);
    // stalls between dependent operations
    add_row("stl_base", op_addi, 23, 0, 0, 32'd7, 0, 1'b1);
    add_row("stl_add", op_add, 24, 23, 23, 32'd0, 1, 1'b1);
    add_row("stl_sll", op_sll, 25, 24, 6, 32'd0, 3, 1'b1);
    add_row("stl_xor", op_xor, 26, 25, 24, 32'd0, 2, 1'b1);
    // squashed writeback
    add_row("sq_imm", op_addi, 27, 0, 0, 32'h0000_1234, 0, 1'b0);
    add_row("sq_add", op_add, 28, 27, 2, 32'd0, 0, 1'b0);
    add_row("sq_r1", op_addi, 1, 0, 0, 32'd9, 1, 1'b0);
    add_row("sq_read", op_add, 29, 27, 28, 32'd0, 0, 1'b1);
    add_row("sq_read_r1", op_add, 30, 1, 0, 32'd0, 0, 1'b1);
    add_row("sq_after", op_addi, 31, 24, 0, rand_word(), 0, 1'b1);

    // each row plus room for a control change
    cycle_limit = 200;
    for (r = 0; r < n_rows; r++) begin
      cycle_limit += 1 + 12 + row_stall[r];
    end

    repeat (4) @(negedge clk);
    resetn = 1'b1;
    check_value("reset wb_valid", 32'd0, {31'd0, wb_valid});
    check_value("reset pslverr", 32'd0, {31'd0, pslverr});
    apb_check("reset ctrl", 1'b0, csr_ctrl_off, 32'd0, 1'b1, 32'd1, 1'b0);
    apb_check("reset commit", 1'b0, csr_commit_off, 32'd0, 1'b1, 32'd0, 1'b0);
    apb_check("reset squash", 1'b0, csr_squash_off, 32'd0, 1'b1, 32'd0, 1'b0);

    for (r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    drain_pipe();

    apb_check("cnt commit", 1'b0, csr_commit_off, 32'd0, 1'b1, 32'(model_commits), 1'b0);
    apb_check("cnt squash", 1'b0, csr_squash_off, 32'd0, 1'b1, 32'(model_squashes), 1'b0);
    apb_check("id read", 1'b0, csr_id_off, 32'd0, 1'b1, opd_id, 1'b0);
    apb_check("commit clear", 1'b1, csr_commit_off, 32'h5a5a_0000, 1'b0, 32'd0, 1'b0);
    apb_check("commit cleared", 1'b0, csr_commit_off, 32'd0, 1'b1, 32'd0, 1'b0);
    apb_check("squash clear", 1'b1, csr_squash_off, 32'hffff_ffff, 1'b0, 32'd0, 1'b0);
    apb_check("squash cleared", 1'b0, csr_squash_off, 32'd0, 1'b1, 32'd0, 1'b0);
    apb_check("unmapped read", 1'b0, 12'h010, 32'd0, 1'b0, 32'd0, 1'b1);
    apb_check("unmapped write", 1'b1, 12'hffc, 32'd1, 1'b0, 32'd0, 1'b1);
    apb_check("id write", 1'b1, csr_id_off, 32'd0, 1'b0, 32'd0, 1'b1);
    apb_check("id after write", 1'b0, csr_id_off, 32'd0, 1'b1, opd_id, 1'b0);
    apb_check("ctrl clear", 1'b1, csr_ctrl_off, 32'd0, 1'b0, 32'd0, 1'b0);
    apb_check("ctrl read zero", 1'b0, csr_ctrl_off, 32'd0, 1'b1, 32'd0, 1'b0);
    apb_check("ctrl set", 1'b1, csr_ctrl_off, 32'd1, 1'b0, 32'd0, 1'b0);
    apb_check("ctrl read one", 1'b0, csr_ctrl_off, 32'd0, 1'b1, 32'd1, 1'b0);

    assert (acc_q.size() == 0) else begin
      $display("accepted operations never produced a writeback result");
      errors++;
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/opd_pkg.sv
design/dpram.sv
design/rf_bank.sv
design/reg_file.sv
design/alu.sv
design/exec_pipe.sv
design/csr_apb.sv
design/opd_top.sv
verif/opd_tb.sv
